// File: src.f
verilog/norm_pkg.sv
verilog/operand_buffer.sv
verilog/param_sequencer.sv
verilog/param_grad_engine.sv
verilog/grad_result_store.sv
verilog/norm_param_top.sv
test/tb_norm_param_top.sv

// File: Bender.yml
package:
  name: norm_param

sources:
  - verilog/norm_pkg.sv
  - verilog/operand_buffer.sv
  - verilog/param_sequencer.sv
  - verilog/param_grad_engine.sv
  - verilog/grad_result_store.sv
  - verilog/norm_param_top.sv
  - target: test
    files:
      - test/tb_norm_param_top.sv

// File: test/tb_norm_param_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_norm_param_top
    import norm_pkg::*;
();

    // Y load, dz load and readback take HIDDEN_DIM cycles each per pass
    localparam int PASS_CYCLES     = 3 * HIDDEN_DIM;
    // Work phases, handshakes and reset
    localparam int MARGIN_CYCLES   = 2 * (HIDDEN_DIM + ENGINE_LATENCY + 2) + 512;
    localparam int TIMEOUT_CYCLES  = 2 * PASS_CYCLES + MARGIN_CYCLES;
    localparam int SEND_WAIT_LIMIT = HIDDEN_DIM + ENGINE_LATENCY + 16;

    logic              clk = 1'b0;
    logic              resetn;
    logic [CTRL_W-1:0] ctrl_reg0;
    logic [CTRL_W-1:0] ctrl_reg1;
    logic [CTRL_W-1:0] constant0;
    logic [CTRL_W-1:0] constant1;
    logic [CTRL_W-1:0] constant2;
    logic [CTRL_W-1:0] status_reg0;
    logic [CTRL_W-1:0] status_reg1;
    logic [CTRL_W-1:0] bm_param_result;

    // Marks a readback address on constant2
    logic read_req;

    logic [OPERAND_W-1:0] y_ref  [HIDDEN_DIM];
    logic [OPERAND_W-1:0] dz_ref [HIDDEN_DIM];

    integer seed;
    int     errors        = 0;
    int     compare_count = 0;

    norm_param_top DUT (
        .clk             (clk),
        .resetn          (resetn),
        .ctrl_reg0       (ctrl_reg0),
        .ctrl_reg1       (ctrl_reg1),
        .constant0       (constant0),
        .constant1       (constant1),
        .constant2       (constant2),
        .status_reg0     (status_reg0),
        .status_reg1     (status_reg1),
        .bm_param_result (bm_param_result)
    );

    always #10 clk = ~clk;

    function automatic logic [CTRL_W-1:0] flag_word(input int bit_pos);
        return CTRL_W'(1) << bit_pos;
    endfunction

    // Wrapping 16-bit sums over the lanes of one hidden index
    function automatic logic [CTRL_W-1:0] expected_result(input int idx);
        logic [LANE_W-1:0]   y_lane;
        logic [LANE_W-1:0]   dz_lane;
        logic [2*LANE_W-1:0] full_prod;
        logic [LANE_W-1:0]   acc_g;
        logic [LANE_W-1:0]   acc_b;
        acc_g = '0;
        acc_b = '0;
        for (int k = 0; k < SEQ_LEN; k++) begin
            y_lane    = y_ref[idx][k*LANE_W +: LANE_W];
            dz_lane   = dz_ref[idx][k*LANE_W +: LANE_W];
            full_prod = dz_lane * y_lane;
            acc_g     = acc_g + full_prod[LANE_W-1:0];
            acc_b     = acc_b + dz_lane;
        end
        return {acc_g, acc_b};
    endfunction

    task automatic check_status(input logic [CTRL_W-1:0] expected);
        assert (status_reg0 === expected) else begin
            errors++;
            $display("FAILED status_reg0: expected 0x%08h, got 0x%08h", expected, status_reg0);
        end
    endtask

    // One cycle high on a ctrl_reg0 finish bit
    task automatic pulse_finish(input int bit_pos);
        @(negedge clk);
        ctrl_reg0          = '0;
        ctrl_reg0[bit_pos] = 1'b1;
        @(negedge clk);
        ctrl_reg0 = '0;
    endtask

    task automatic pulse_start();
        @(negedge clk);
        ctrl_reg1                  = '0;
        ctrl_reg1[BIT_PARAM_START] = 1'b1;
        @(negedge clk);
        ctrl_reg1 = '0;
    endtask

    task automatic generate_operands();
        for (int i = 0; i < HIDDEN_DIM; i++) begin
            y_ref[i]  = {$random(seed), $random(seed)};
            dz_ref[i] = {$random(seed), $random(seed)};
        end
    endtask

    // constant1 holds the low half of the entry
    task automatic load_operands(input logic is_dz);
        logic [OPERAND_W-1:0] word;
        for (int i = 0; i < HIDDEN_DIM; i++) begin
            word = is_dz ? dz_ref[i] : y_ref[i];
            @(negedge clk);
            constant0 = word[OPERAND_W-1:CTRL_W];
            constant1 = word[CTRL_W-1:0];
            constant2 = CTRL_W'(i);
        end
    endtask

    task automatic wait_for_send();
        int cycles;
        cycles = 0;
        while (!status_reg0[BIT_ST_SEND] && cycles < SEND_WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (status_reg0[BIT_ST_SEND]) else begin
            errors++;
            $display("Send phase not reached within %0d cycles of work", SEND_WAIT_LIMIT);
        end
    endtask

    task automatic read_results();
        for (int i = 0; i < HIDDEN_DIM; i++) begin
            @(negedge clk);
            constant2 = CTRL_W'(i);
            read_req  = 1'b1;
        end
        @(negedge clk);
        read_req = 1'b0;
    endtask

    task automatic run_pass();
        generate_operands();
        pulse_start();
        check_status(flag_word(BIT_ST_INIT_Y));
        // Strobes meant for other phases
        pulse_finish(BIT_DZ_DONE);
        check_status(flag_word(BIT_ST_INIT_Y));
        pulse_finish(BIT_SEND_DONE);
        check_status(flag_word(BIT_ST_INIT_Y));
        pulse_start();
        check_status(flag_word(BIT_ST_INIT_Y));
        load_operands(1'b0);
        pulse_finish(BIT_Y_DONE);
        check_status(flag_word(BIT_ST_INIT_DZ));
        pulse_finish(BIT_Y_DONE);
        check_status(flag_word(BIT_ST_INIT_DZ));
        pulse_start();
        check_status(flag_word(BIT_ST_INIT_DZ));
        load_operands(1'b1);
        pulse_finish(BIT_DZ_DONE);
        // Work phase has no flag of its own
        check_status('0);
        pulse_finish(BIT_SEND_DONE);
        check_status('0);
        wait_for_send();
        check_status(flag_word(BIT_ST_SEND));
        pulse_finish(BIT_Y_DONE);
        check_status(flag_word(BIT_ST_SEND));
        pulse_finish(BIT_DZ_DONE);
        check_status(flag_word(BIT_ST_SEND));
        read_results();
        pulse_finish(BIT_SEND_DONE);
        check_status(flag_word(BIT_ST_IDLE));
    endtask

    initial begin : stimulus
        seed      = 32'h7319b271;
        resetn    = 1'b0;
        ctrl_reg0 = '0;
        ctrl_reg1 = '0;
        constant0 = '0;
        constant1 = '0;
        constant2 = '0;
        read_req  = 1'b0;
        repeat (8) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        check_status(flag_word(BIT_ST_IDLE));
        pulse_finish(BIT_Y_DONE);
        check_status(flag_word(BIT_ST_IDLE));
        pulse_finish(BIT_DZ_DONE);
        check_status(flag_word(BIT_ST_IDLE));
        pulse_finish(BIT_SEND_DONE);
        check_status(flag_word(BIT_ST_IDLE));
        run_pass();
        // Second pass with fresh operands from index zero
        run_pass();
        repeat (2) @(negedge clk);
        assert (compare_count == 2 * HIDDEN_DIM) else begin
            errors++;
            $display("Readback compared %0d entries instead of %0d",
                     compare_count, 2 * HIDDEN_DIM);
        end
        $display("Finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Address taken at the rising edge and result checked at the next falling edge
    initial begin : compare_results
        logic              issued;
        int                idx;
        logic [CTRL_W-1:0] expected;
        logic [CTRL_W-1:0] held_cycles;
        logic              was_send;
        issued      = 1'b0;
        idx         = 0;
        expected    = '0;
        held_cycles = '0;
        was_send    = 1'b0;
        wait (resetn === 1'b1);
        forever begin
            @(posedge clk);
            issued   = read_req;
            idx      = int'(constant2[ADDR_W-1:0]);
            expected = expected_result(idx);
            @(negedge clk);
            if (issued) begin
                compare_count++;
                assert (bm_param_result === expected) else begin
                    errors++;
                    $display("FAILED bm_param_result at index %0d: expected 0x%08h, got 0x%08h",
                             idx, expected, bm_param_result);
                end
            end
            if (status_reg0[BIT_ST_SEND]) begin
                if (!was_send) begin
                    assert (status_reg1 >= HIDDEN_DIM &&
                            status_reg1 <= HIDDEN_DIM + ENGINE_LATENCY + 2) else begin
                        errors++;
                        $display("FAILED status_reg1: 0x%08h outside 0x%08h to 0x%08h",
                                 status_reg1, HIDDEN_DIM, HIDDEN_DIM + ENGINE_LATENCY + 2);
                    end
                    held_cycles = status_reg1;
                end else begin
                    assert (status_reg1 === held_cycles) else begin
                        errors++;
                        $display("FAILED status_reg1: expected 0x%08h, got 0x%08h",
                                 held_cycles, status_reg1);
                    end
                end
            end else begin
                assert (bm_param_result === '0) else begin
                    errors++;
                    $display("FAILED bm_param_result: expected 0x%08h, got 0x%08h",
                             32'h0, bm_param_result);
                end
                assert (status_reg1 === '0) else begin
                    errors++;
                    $display("FAILED status_reg1: expected 0x%08h, got 0x%08h",
                             32'h0, status_reg1);
                end
            end
            was_send = status_reg0[BIT_ST_SEND];
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        errors++;
        $display("Timeout after %0d cycles, the run did not complete", TIMEOUT_CYCLES);
        $display("Finished with %0d errors", errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/norm_param_top.sv
`timescale 1ns/1ps
`default_nettype none

module norm_param_top
    import norm_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    input  logic [CTRL_W-1:0] ctrl_reg0,
    input  logic [CTRL_W-1:0] ctrl_reg1,
    input  logic [CTRL_W-1:0] constant0,
    input  logic [CTRL_W-1:0] constant1,
    input  logic [CTRL_W-1:0] constant2,
    output logic [CTRL_W-1:0] status_reg0,
    output logic [CTRL_W-1:0] status_reg1,
    output logic [CTRL_W-1:0] bm_param_result
);

    logic start;
    logic y_done;
    logic dz_done;
    logic send_done;

    logic y_load;
    logic dz_load;
    logic work_start;
    logic result_read;
    logic idle;
    logic [CTRL_W-1:0] work_cycles;

    logic [OPERAND_W-1:0] entry_data;
    logic [ADDR_W-1:0]    entry_addr;

    logic [ADDR_W-1:0]    rd_addr;
    logic [OPERAND_W-1:0] y_data;
    logic [OPERAND_W-1:0] dz_data;
    logic [LANE_W-1:0]    gradg;
    logic [LANE_W-1:0]    gradb;
    logic                 result_valid;
    logic                 result_last;

    assign start     = ctrl_reg1[BIT_PARAM_START];
    assign y_done    = ctrl_reg0[BIT_Y_DONE];
    assign dz_done   = ctrl_reg0[BIT_DZ_DONE];
    assign send_done = ctrl_reg0[BIT_SEND_DONE];

    // constant1 carries lanes 0 and 1
    assign entry_data = {constant0, constant1};
    assign entry_addr = constant2[ADDR_W-1:0];

    always_comb begin
        status_reg0                 = '0;
        status_reg0[BIT_ST_IDLE]    = idle;
        status_reg0[BIT_ST_INIT_Y]  = y_load;
        status_reg0[BIT_ST_INIT_DZ] = dz_load;
        status_reg0[BIT_ST_SEND]    = result_read;
    end

    assign status_reg1 = result_read ? work_cycles : '0;

    param_sequencer u_sequencer (
        .clk         (clk),
        .resetn      (resetn),
        .start       (start),
        .y_done      (y_done),
        .dz_done     (dz_done),
        .send_done   (send_done),
        .result_last (result_last),
        .y_load      (y_load),
        .dz_load     (dz_load),
        .work_start  (work_start),
        .result_read (result_read),
        .idle        (idle),
        .work_cycles (work_cycles)
    );

    operand_buffer #(
        .WIDTH (OPERAND_W),
        .DEPTH (HIDDEN_DIM)
    ) y_buffer (
        .clk     (clk),
        .wr_en   (y_load),
        .wr_addr (entry_addr),
        .wr_data (entry_data),
        .rd_addr (rd_addr),
        .rd_data (y_data)
    );

    operand_buffer #(
        .WIDTH (OPERAND_W),
        .DEPTH (HIDDEN_DIM)
    ) dz_buffer (
        .clk     (clk),
        .wr_en   (dz_load),
        .wr_addr (entry_addr),
        .wr_data (entry_data),
        .rd_addr (rd_addr),
        .rd_data (dz_data)
    );

    param_grad_engine u_engine (
        .clk          (clk),
        .resetn       (resetn),
        .start        (work_start),
        .y_data       (y_data),
        .dz_data      (dz_data),
        .rd_addr      (rd_addr),
        .gradg        (gradg),
        .gradb        (gradb),
        .result_valid (result_valid),
        .result_last  (result_last)
    );

    grad_result_store u_result_store (
        .clk          (clk),
        .resetn       (resetn),
        .gradg        (gradg),
        .gradb        (gradb),
        .result_valid (result_valid),
        .result_last  (result_last),
        .read_en      (result_read),
        .read_addr    (entry_addr),
        .result_word  (bm_param_result)
    );

endmodule

`default_nettype wire

// File: verilog/grad_result_store.sv
`timescale 1ns/1ps
`default_nettype none

module grad_result_store
    import norm_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    input  logic [LANE_W-1:0] gradg,
    input  logic [LANE_W-1:0] gradb,
    input  logic              result_valid,
    input  logic              result_last,
    input  logic              read_en,
    input  logic [ADDR_W-1:0] read_addr,
    output logic [CTRL_W-1:0] result_word
);

    logic [ADDR_W-1:0] wr_ptr;
    logic [LANE_W-1:0] gradg_q;
    logic [LANE_W-1:0] gradb_q;

    // Results land in arrival order, next pass starts at zero
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wr_ptr <= '0;
        end else if (result_valid) begin
            if (result_last) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    operand_buffer #(
        .WIDTH (LANE_W),
        .DEPTH (HIDDEN_DIM)
    ) gradg_buffer (
        .clk     (clk),
        .wr_en   (result_valid),
        .wr_addr (wr_ptr),
        .wr_data (gradg),
        .rd_addr (read_addr),
        .rd_data (gradg_q)
    );

    operand_buffer #(
        .WIDTH (LANE_W),
        .DEPTH (HIDDEN_DIM)
    ) gradb_buffer (
        .clk     (clk),
        .wr_en   (result_valid),
        .wr_addr (wr_ptr),
        .wr_data (gradb),
        .rd_addr (read_addr),
        .rd_data (gradb_q)
    );

    // Zero outside the send phase
    assign result_word = read_en ? {gradg_q, gradb_q} : '0;

endmodule

`default_nettype wire

// File: verilog/param_grad_engine.sv
`timescale 1ns/1ps
`default_nettype none

module param_grad_engine
    import norm_pkg::*;
(
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 start,
    input  logic [OPERAND_W-1:0] y_data,
    input  logic [OPERAND_W-1:0] dz_data,
    output logic [ADDR_W-1:0]    rd_addr,
    output logic [LANE_W-1:0]    gradg,
    output logic [LANE_W-1:0]    gradb,
    output logic                 result_valid,
    output logic                 result_last
);

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(HIDDEN_DIM - 1);

    logic              busy;
    logic [ADDR_W-1:0] addr;
    logic              issue;
    logic              issue_last;

    // Stage markers, index 0 is the read data stage
    logic [ENGINE_LATENCY-1:0] vld_sr;
    logic [ENGINE_LATENCY-1:0] last_sr;

    logic [LANE_W-1:0] lane_prod [SEQ_LEN];
    logic [LANE_W-1:0] sum_g;
    logic [LANE_W-1:0] sum_b;

    assign issue      = busy;
    assign issue_last = busy && (addr == LAST_ADDR);
    assign rd_addr    = addr;

    // Address walker, one index per cycle
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            busy <= 1'b0;
            addr <= '0;
        end else if (start) begin
            busy <= 1'b1;
            addr <= '0;
        end else if (busy) begin
            if (issue_last) begin
                busy <= 1'b0;
                addr <= '0;
            end else begin
                addr <= addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            vld_sr  <= '0;
            last_sr <= '0;
        end else begin
            vld_sr  <= {vld_sr[ENGINE_LATENCY-2:0], issue};
            last_sr <= {last_sr[ENGINE_LATENCY-2:0], issue_last};
        end
    end

    // Lane products keep their low 16 bits
    always_comb begin
        sum_g = '0;
        sum_b = '0;
        for (int k = 0; k < SEQ_LEN; k++) begin
            lane_prod[k] = dz_data[k*LANE_W +: LANE_W] * y_data[k*LANE_W +: LANE_W];
            sum_g        = sum_g + lane_prod[k];
            sum_b        = sum_b + dz_data[k*LANE_W +: LANE_W];
        end
    end

    // Compute stage
    always_ff @(posedge clk) begin
        if (vld_sr[ENGINE_LATENCY-2]) begin
            gradg <= sum_g;
            gradb <= sum_b;
        end
    end

    assign result_valid = vld_sr[ENGINE_LATENCY-1];
    assign result_last  = last_sr[ENGINE_LATENCY-1];

    a_last_with_valid: assert property (
        @(posedge clk) disable iff (!resetn)
        result_last |-> result_valid
    );

endmodule

`default_nettype wire

// File: verilog/param_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module param_sequencer
    import norm_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    input  logic              start,
    input  logic              y_done,
    input  logic              dz_done,
    input  logic              send_done,
    input  logic              result_last,
    output logic              y_load,
    output logic              dz_load,
    output logic              work_start,
    output logic              result_read,
    output logic              idle,
    output logic [CTRL_W-1:0] work_cycles
);

    param_state_e state;
    param_state_e next_state;

    // High once the work phase has been entered
    logic in_work_q;

    logic count_en;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Strobes outside their own phase are simply ignored
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    next_state = ST_INIT_Y;
                end
            end
            ST_INIT_Y: begin
                if (y_done) begin
                    next_state = ST_INIT_DZ;
                end
            end
            ST_INIT_DZ: begin
                if (dz_done) begin
                    next_state = ST_WORK;
                end
            end
            ST_WORK: begin
                // Engine reports its final index
                if (result_last) begin
                    next_state = ST_SEND;
                end
            end
            ST_SEND: begin
                if (send_done) begin
                    next_state = ST_IDLE;
                end
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    // Per-phase decode straight from the state register
    assign idle        = (state == ST_IDLE);
    assign y_load      = (state == ST_INIT_Y);
    assign dz_load     = (state == ST_INIT_DZ);
    assign result_read = (state == ST_SEND);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            in_work_q <= 1'b0;
        end else begin
            in_work_q <= (state == ST_WORK);
        end
    end

    // First cycle of the work phase only
    assign work_start = (state == ST_WORK) && !in_work_q;

    // Work cycle counter
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            count_en <= 1'b0;
        end else if (work_start) begin
            count_en <= 1'b1;
        end else if (result_last) begin
            count_en <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            work_cycles <= '0;
        end else if (work_start) begin
            work_cycles <= '0;
        end else if (count_en && !result_last) begin
            work_cycles <= work_cycles + 1'b1;
        end
    end

    // Engine must never be launched twice in a row
    a_single_work_start: assert property (
        @(posedge clk) disable iff (!resetn)
        work_start |=> !work_start
    );

endmodule

`default_nettype wire

// File: verilog/operand_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module operand_buffer
    import norm_pkg::*;
#(
    parameter int WIDTH = OPERAND_W,
    parameter int DEPTH = HIDDEN_DIM
) (
    input  logic              clk,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [WIDTH-1:0]  wr_data,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [WIDTH-1:0]  rd_data
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    a_wr_addr_known: assert property (
        @(posedge clk) wr_en |-> !$isunknown(wr_addr)
    );

endmodule

`default_nettype wire

// File: verilog/norm_pkg.sv
`default_nettype none

package norm_pkg;

    // Operand geometry
    localparam int LANE_W     = 16;
    localparam int SEQ_LEN    = 4;
    localparam int OPERAND_W  = LANE_W * SEQ_LEN;
    localparam int HIDDEN_DIM = 512;
    localparam int ADDR_W     = $clog2(HIDDEN_DIM);
    localparam int CTRL_W     = 32;

    // Finish bits in ctrl_reg0
    localparam int BIT_Y_DONE    = 7;
    localparam int BIT_DZ_DONE   = 8;
    localparam int BIT_SEND_DONE = 9;

    // Start strobe in ctrl_reg1
    localparam int BIT_PARAM_START = 2;

    // Phase flags in status_reg0
    localparam int BIT_ST_IDLE    = 6;
    localparam int BIT_ST_INIT_Y  = 7;
    localparam int BIT_ST_INIT_DZ = 8;
    localparam int BIT_ST_SEND    = 9;

    // Address issue to registered result
    localparam int ENGINE_LATENCY = 2;

    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_INIT_Y  = 3'd1,
        ST_INIT_DZ = 3'd2,
        ST_WORK    = 3'd3,
        ST_SEND    = 3'd4
    } param_state_e;

endpackage

`default_nettype wire
